// File: Bender.yml
package:
  name: rename_alloc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/instr_pkg.sv
      - hw/core_pkg.sv
      - hw/decode_stage.sv
      - hw/rename_stage.sv
      - hw/alloc_stage.sv
      - hw/rob_tracker.sv
      - hw/rename_alloc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_rename_alloc.sv

// File: build.f
+incdir+include
hw/instr_pkg.sv
hw/core_pkg.sv
hw/decode_stage.sv
hw/rename_stage.sv
hw/alloc_stage.sv
hw/rob_tracker.sv
hw/rename_alloc_top.sv
tb/tb_rename_alloc.sv

// File: hw/alloc_stage.sv
`timescale 1ns/100ps

module alloc_stage (
   input  logic               clk,
   input  logic               reset,
   input  logic               stall,
   input  logic               ren_valid,
   input  instr_pkg::t_alu_op ren_op,
   input  core_pkg::t_areg    ren_rs1,
   input  core_pkg::t_areg    ren_rs2,
   input  logic               ren_use_rs2,
   input  logic [31:0]        ren_imm,
   input  logic               ren_illegal,
   input  core_pkg::t_preg    ren_psrc1,
   input  core_pkg::t_preg    ren_psrc2,
   input  core_pkg::t_preg    ren_pdst,
   input  core_pkg::t_rob_id  next_robid,
   output core_pkg::t_areg    src_areg1,
   output core_pkg::t_areg    src_areg2,
   input  logic               src_pdg1,
   input  logic               src_pdg2,
   input  core_pkg::t_rob_id  src_robid1,
   input  core_pkg::t_rob_id  src_robid2,
   output logic               alloc,
   output logic               disp_valid,
   output core_pkg::t_rob_id  disp_robid,
   output instr_pkg::t_alu_op disp_op,
   output logic [31:0]        disp_imm,
   output logic               disp_use_rs2,
   output logic               disp_illegal,
   output core_pkg::t_preg    disp_pdst,
   output core_pkg::t_preg    disp_psrc1,
   output core_pkg::t_preg    disp_psrc2,
   output logic               disp_pdg1,
   output logic               disp_pdg2,
   output core_pkg::t_rob_id  disp_src_robid1,
   output core_pkg::t_rob_id  disp_src_robid2
);

   // The tracker answers for both sources in the same cycle.
   assign src_areg1 = ren_rs1;
   assign src_areg2 = ren_rs2;

   // A valid instruction takes the ROB tail only when nothing stalls.
   assign alloc = ren_valid && !stall;

   always_ff @(posedge clk) begin
      if (reset) begin
         disp_valid <= 1'b0;
      end else begin
         disp_valid <= alloc;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         disp_robid      <= next_robid;
         disp_op         <= ren_op;
         disp_imm        <= ren_imm;
         disp_use_rs2    <= ren_use_rs2;
         disp_illegal    <= ren_illegal;
         disp_pdst       <= ren_pdst;
         disp_psrc1      <= ren_psrc1;
         disp_psrc2      <= ren_psrc2;
         disp_pdg1       <= src_pdg1;
         disp_pdg2       <= src_pdg2;
         disp_src_robid1 <= src_robid1;
         disp_src_robid2 <= src_robid2;
      end
   end

endmodule

// File: hw/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

   typedef logic [$clog2(`NUM_AREGS)-1:0] t_areg;

   typedef logic [$clog2(`NUM_PREGS)-1:0] t_preg;

   typedef logic [$clog2(`ROB_DEPTH)-1:0] t_rob_id;

   // Occupancy counters need one bit more than the index.
   typedef logic [$clog2(`NUM_PREGS):0] t_free_cnt;

   typedef logic [$clog2(`ROB_DEPTH):0] t_rob_cnt;

endpackage

// File: hw/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 stall,
   input  logic                 instr_valid,
   input  instr_pkg::t_instr_word instr_word,
   output logic                 dec_valid,
   output instr_pkg::t_alu_op   dec_op,
   output core_pkg::t_areg      dec_rd,
   output core_pkg::t_areg      dec_rs1,
   output core_pkg::t_areg      dec_rs2,
   output logic                 dec_use_rs2,
   output logic [31:0]          dec_imm,
   output logic                 dec_illegal
);

   import instr_pkg::*;
   import core_pkg::*;

   t_instr_union instr_u;
   t_alu_op      op_d;
   t_areg        rd_d;
   t_areg        rs1_d;
   t_areg        rs2_d;
   logic         use_rs2_d;
   logic [31:0]  imm_d;
   logic         illegal_d;
   logic         r_ok;
   logic         shift_ok;

   assign instr_u = instr_word;

   // Only the add/sub pair may use the alternate funct7.
   assign r_ok = (instr_u.r.funct7 == F7_BASE) ||
                 (instr_u.r.funct7 == F7_ALT && instr_u.r.funct3 == 3'b000);
   assign shift_ok = (instr_u.i.imm12[11:5] == F7_BASE);

   always_comb begin
      op_d      = ALU_ADD;
      rd_d      = '0;
      rs1_d     = '0;
      rs2_d     = '0;
      use_rs2_d = 1'b0;
      imm_d     = '0;
      illegal_d = 1'b1;
      if (instr_u.r.opcode == OPC_OP && r_ok) begin
         illegal_d = 1'b0;
         case (instr_u.r.funct3)
            3'b000:  op_d = (instr_u.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
            3'b001:  op_d = ALU_SLL;
            3'b010:  op_d = ALU_SLT;
            3'b100:  op_d = ALU_XOR;
            3'b101:  op_d = ALU_SRL;
            3'b110:  op_d = ALU_OR;
            3'b111:  op_d = ALU_AND;
            default: illegal_d = 1'b1;
         endcase
         if (!illegal_d) begin
            rd_d      = instr_u.r.rd;
            rs1_d     = instr_u.r.rs1;
            rs2_d     = instr_u.r.rs2;
            use_rs2_d = 1'b1;
         end
      end else if (instr_u.i.opcode == OPC_OP_IMM) begin
         illegal_d = 1'b0;
         case (instr_u.i.funct3)
            3'b000:  op_d = ALU_ADD;
            3'b010:  op_d = ALU_SLT;
            3'b100:  op_d = ALU_XOR;
            3'b110:  op_d = ALU_OR;
            3'b111:  op_d = ALU_AND;
            3'b001:  op_d = ALU_SLL;
            3'b101:  op_d = ALU_SRL;
            default: illegal_d = 1'b1;
         endcase
         // Shift immediates carry only a shift amount.
         if ((instr_u.i.funct3 == 3'b001 || instr_u.i.funct3 == 3'b101) && !shift_ok) begin
            illegal_d = 1'b1;
         end
         if (!illegal_d) begin
            rd_d  = instr_u.i.rd;
            rs1_d = instr_u.i.rs1;
            imm_d = {{20{instr_u.i.imm12[11]}}, instr_u.i.imm12};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         dec_valid <= 1'b0;
      end else if (!stall) begin
         dec_valid <= instr_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         dec_op      <= op_d;
         dec_rd      <= rd_d;
         dec_rs1     <= rs1_d;
         dec_rs2     <= rs2_d;
         dec_use_rs2 <= use_rs2_d;
         dec_imm     <= imm_d;
         dec_illegal <= illegal_d;
      end
   end

endmodule

// File: hw/instr_pkg.sv
`include "core_settings.svh"

package instr_pkg;

   // Register fields in the encoding are sized by the register count.
   localparam int REG_FIELD_W = $clog2(`NUM_AREGS);

   typedef logic [31:0] t_instr_word;

   typedef struct packed {
      logic [6:0]             funct7;
      logic [REG_FIELD_W-1:0] rs2;
      logic [REG_FIELD_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [REG_FIELD_W-1:0] rd;
      logic [6:0]             opcode;
   } t_r_form;

   typedef struct packed {
      logic [11:0]            imm12;
      logic [REG_FIELD_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [REG_FIELD_W-1:0] rd;
      logic [6:0]             opcode;
   } t_i_form;

   // Bits 31:20 are funct7 and rs2 in one form, the immediate in the other.
   typedef union packed {
      t_r_form r;
      t_i_form i;
   } t_instr_union;

   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SLT = 4'd5,
      ALU_SLL = 4'd6,
      ALU_SRL = 4'd7
   } t_alu_op;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   // funct7 values seen in the supported R forms.
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// File: hw/rename_alloc_top.sv
`timescale 1ns/100ps

module rename_alloc_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   instr_valid,
   input  instr_pkg::t_instr_word instr_word,
   output logic                   fe_ready,
   input  logic                   rs_stall,
   input  logic                   complete_valid,
   input  core_pkg::t_rob_id      complete_robid,
   output logic                   retire_valid,
   output core_pkg::t_rob_id      retire_robid,
   output logic                   disp_valid,
   output core_pkg::t_rob_id      disp_robid,
   output instr_pkg::t_alu_op     disp_op,
   output logic [31:0]            disp_imm,
   output logic                   disp_use_rs2,
   output logic                   disp_illegal,
   output core_pkg::t_preg        disp_pdst,
   output core_pkg::t_preg        disp_psrc1,
   output core_pkg::t_preg        disp_psrc2,
   output logic                   disp_pdg1,
   output logic                   disp_pdg2,
   output core_pkg::t_rob_id      disp_src_robid1,
   output core_pkg::t_rob_id      disp_src_robid2
);

   import instr_pkg::*;
   import core_pkg::*;

   logic        stall;
   logic        need_dest;

   // Decode to rename.
   logic        dec_valid;
   t_alu_op     dec_op;
   t_areg       dec_rd;
   t_areg       dec_rs1;
   t_areg       dec_rs2;
   logic        dec_use_rs2;
   logic [31:0] dec_imm;
   logic        dec_illegal;

   // Rename to alloc and tracker.
   logic        ren_valid;
   t_alu_op     ren_op;
   t_areg       ren_rd;
   t_areg       ren_rs1;
   t_areg       ren_rs2;
   logic        ren_use_rs2;
   logic [31:0] ren_imm;
   logic        ren_illegal;
   t_preg       ren_psrc1;
   t_preg       ren_psrc2;
   t_preg       ren_pdst;
   t_preg       ren_old_pdst;
   logic        ren_has_dest;

   // Alloc and tracker.
   t_rob_id     next_robid;
   t_areg       src_areg1;
   t_areg       src_areg2;
   logic        src_pdg1;
   logic        src_pdg2;
   t_rob_id     src_robid1;
   t_rob_id     src_robid2;
   logic        alloc;
   logic        rob_full;
   logic        free_empty;
   logic        free_valid;
   t_preg       free_preg;

   // Illegal words arrive with rd cleared, so rd alone tells.
   assign need_dest = dec_valid && (dec_rd != '0);

   // One stall level freezes all three stages together.
   assign stall    = rs_stall || rob_full || (free_empty && need_dest);
   assign fe_ready = !stall;

   decode_stage decode_stage_i (.*);

   rename_stage rename_stage_i (.*);

   alloc_stage alloc_stage_i (.*);

   rob_tracker rob_tracker_i (
      .*,
      .alloc_rd       (ren_rd),
      .alloc_has_dest (ren_has_dest),
      .alloc_old_pdst (ren_old_pdst)
   );

endmodule

// File: hw/rename_stage.sv
`timescale 1ns/100ps

`include "core_settings.svh"

module rename_stage (
   input  logic               clk,
   input  logic               reset,
   input  logic               stall,
   input  logic               dec_valid,
   input  instr_pkg::t_alu_op dec_op,
   input  core_pkg::t_areg    dec_rd,
   input  core_pkg::t_areg    dec_rs1,
   input  core_pkg::t_areg    dec_rs2,
   input  logic               dec_use_rs2,
   input  logic [31:0]        dec_imm,
   input  logic               dec_illegal,
   input  logic               free_valid,
   input  core_pkg::t_preg    free_preg,
   output logic               free_empty,
   output logic               ren_valid,
   output instr_pkg::t_alu_op ren_op,
   output core_pkg::t_areg    ren_rd,
   output core_pkg::t_areg    ren_rs1,
   output core_pkg::t_areg    ren_rs2,
   output logic               ren_use_rs2,
   output logic [31:0]        ren_imm,
   output logic               ren_illegal,
   output core_pkg::t_preg    ren_psrc1,
   output core_pkg::t_preg    ren_psrc2,
   output core_pkg::t_preg    ren_pdst,
   output core_pkg::t_preg    ren_old_pdst,
   output logic               ren_has_dest
);

   import core_pkg::*;

   // Alias table and free-list storage.
   t_preg     rat      [`NUM_AREGS];
   t_preg     free_mem [`NUM_PREGS];
   t_preg     free_head;
   t_preg     free_tail;
   t_free_cnt free_count;
   logic      has_dest;
   logic      pop;

   // x0 keeps its fixed mapping.
   assign has_dest   = !dec_illegal && (dec_rd != '0);
   assign pop        = dec_valid && has_dest && !stall;
   assign free_empty = (free_count == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `NUM_AREGS; i++) begin
            rat[i] <= t_preg'(i);
         end
         for (int i = 0; i < `NUM_PREGS - `NUM_AREGS; i++) begin
            free_mem[i] <= t_preg'(i + `NUM_AREGS);
         end
         free_head  <= '0;
         free_tail  <= t_preg'(`NUM_PREGS - `NUM_AREGS);
         free_count <= t_free_cnt'(`NUM_PREGS - `NUM_AREGS);
      end else begin
         if (pop) begin
            rat[dec_rd] <= free_mem[free_head];
            free_head   <= free_head + 1'b1;
         end
         if (free_valid) begin
            free_mem[free_tail] <= free_preg;
            free_tail           <= free_tail + 1'b1;
         end
         case ({pop, free_valid})
            2'b10:   free_count <= free_count - 1'b1;
            2'b01:   free_count <= free_count + 1'b1;
            default: free_count <= free_count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ren_valid <= 1'b0;
      end else if (!stall) begin
         ren_valid <= dec_valid;
      end
   end

   // Sources read the table before this instruction's own update lands.
   always_ff @(posedge clk) begin
      if (!stall) begin
         ren_op       <= dec_op;
         ren_rd       <= dec_rd;
         ren_rs1      <= dec_rs1;
         ren_rs2      <= dec_rs2;
         ren_use_rs2  <= dec_use_rs2;
         ren_imm      <= dec_imm;
         ren_illegal  <= dec_illegal;
         ren_psrc1    <= rat[dec_rs1];
         ren_psrc2    <= rat[dec_rs2];
         ren_pdst     <= has_dest ? free_mem[free_head] : '0;
         ren_old_pdst <= rat[dec_rd];
         ren_has_dest <= has_dest;
      end
   end

endmodule

// File: hw/rob_tracker.sv
`timescale 1ns/100ps

`include "core_settings.svh"

module rob_tracker (
   input  logic              clk,
   input  logic              reset,
   input  logic              alloc,
   input  core_pkg::t_areg   alloc_rd,
   input  logic              alloc_has_dest,
   input  core_pkg::t_preg   alloc_old_pdst,
   output core_pkg::t_rob_id next_robid,
   output logic              rob_full,
   input  core_pkg::t_areg   src_areg1,
   input  core_pkg::t_areg   src_areg2,
   output logic              src_pdg1,
   output logic              src_pdg2,
   output core_pkg::t_rob_id src_robid1,
   output core_pkg::t_rob_id src_robid2,
   input  logic              complete_valid,
   input  core_pkg::t_rob_id complete_robid,
   output logic              retire_valid,
   output core_pkg::t_rob_id retire_robid,
   output logic              free_valid,
   output core_pkg::t_preg   free_preg
);

   import core_pkg::*;

   logic    rob_valid    [`ROB_DEPTH];
   logic    rob_complete [`ROB_DEPTH];
   logic    rob_has_dest [`ROB_DEPTH];
   t_preg   rob_old_pdst [`ROB_DEPTH];
   t_areg   rob_rd       [`ROB_DEPTH];

   // Last writer of each architectural register.
   logic    lw_valid [`NUM_AREGS];
   t_rob_id lw_robid [`NUM_AREGS];

   t_rob_id  head;
   t_rob_id  tail;
   t_rob_cnt count;
   logic     retire_now;
   logic     clear_lw;

   assign next_robid = tail;
   assign rob_full   = (count == t_rob_cnt'(`ROB_DEPTH));
   assign retire_now = rob_valid[head] && rob_complete[head];

   // Drop the last-writer link only if no younger writer replaced it.
   assign clear_lw = retire_now && rob_has_dest[head] &&
                     lw_valid[rob_rd[head]] && (lw_robid[rob_rd[head]] == head);

   assign src_pdg1   = (src_areg1 != '0) && lw_valid[src_areg1] &&
                       !rob_complete[lw_robid[src_areg1]];
   assign src_pdg2   = (src_areg2 != '0) && lw_valid[src_areg2] &&
                       !rob_complete[lw_robid[src_areg2]];
   assign src_robid1 = lw_robid[src_areg1];
   assign src_robid2 = lw_robid[src_areg2];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `ROB_DEPTH; i++) begin
            rob_valid[i]    <= 1'b0;
            rob_complete[i] <= 1'b0;
         end
         for (int i = 0; i < `NUM_AREGS; i++) begin
            lw_valid[i] <= 1'b0;
         end
         head         <= '0;
         tail         <= '0;
         count        <= '0;
         retire_valid <= 1'b0;
         free_valid   <= 1'b0;
      end else begin
         retire_valid <= retire_now;
         free_valid   <= retire_now && rob_has_dest[head];
         if (complete_valid) begin
            rob_complete[complete_robid] <= 1'b1;
         end
         if (retire_now) begin
            rob_valid[head] <= 1'b0;
            head            <= head + 1'b1;
         end
         if (clear_lw) begin
            lw_valid[rob_rd[head]] <= 1'b0;
         end
         // A new writer of the same register wins over the clear above.
         if (alloc) begin
            rob_valid[tail]    <= 1'b1;
            rob_complete[tail] <= 1'b0;
            tail               <= tail + 1'b1;
            if (alloc_has_dest) begin
               lw_valid[alloc_rd] <= 1'b1;
            end
         end
         case ({alloc, retire_now})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         rob_has_dest[tail] <= alloc_has_dest;
         rob_old_pdst[tail] <= alloc_old_pdst;
         rob_rd[tail]       <= alloc_rd;
         if (alloc_has_dest) begin
            lw_robid[alloc_rd] <= tail;
         end
      end
      if (retire_now) begin
         retire_robid <= head;
         free_preg    <= rob_old_pdst[head];
      end
   end

endmodule

// File: include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Architectural integer registers, x0 included.
`define NUM_AREGS 32

// Physical register file size, a power of two.
`define NUM_PREGS 64

// Reorder-buffer entries, a power of two.
`define ROB_DEPTH 16

`endif

// File: tb/tb_rename_alloc.sv
`timescale 1ns/100ps

`include "core_settings.svh"

module tb_rename_alloc;

   import instr_pkg::*;
   import core_pkg::*;

   localparam int CLK_PERIOD    = 100;
   localparam int NUM_RANDOM    = 48;
   localparam int COMP_NONE     = 0;
   localparam int COMP_OLDEST   = 1;
   localparam int COMP_YOUNGEST = 2;
   localparam int COMP_RANDOM   = 3;

   typedef struct {
      t_instr_word word;
      t_alu_op     op;
      logic        illegal;
      logic        stall;
      int          comp;
   } row_t;

   typedef struct {
      t_alu_op     op;
      logic        illegal;
      t_areg       rd;
      t_areg       rs1;
      t_areg       rs2;
      logic        use2;
      logic        is_imm;
      logic [31:0] imm;
   } ref_instr_t;

   logic        clk;
   logic        reset;
   logic        instr_valid;
   t_instr_word instr_word;
   logic        fe_ready;
   logic        rs_stall;
   logic        complete_valid;
   t_rob_id     complete_robid;
   logic        retire_valid;
   t_rob_id     retire_robid;
   logic        disp_valid;
   t_rob_id     disp_robid;
   t_alu_op     disp_op;
   logic [31:0] disp_imm;
   logic        disp_use_rs2;
   logic        disp_illegal;
   t_preg       disp_pdst;
   t_preg       disp_psrc1;
   t_preg       disp_psrc2;
   logic        disp_pdg1;
   logic        disp_pdg2;
   t_rob_id     disp_src_robid1;
   t_rob_id     disp_src_robid2;

   // Reference model state.
   t_preg      m_rat      [`NUM_AREGS];
   logic       lw_v       [`NUM_AREGS];
   t_rob_id    lw_id      [`NUM_AREGS];
   logic       m_done     [`ROB_DEPTH];
   logic       m_has_dest [`ROB_DEPTH];
   t_preg      m_old      [`ROB_DEPTH];
   t_areg      m_rd       [`ROB_DEPTH];
   t_preg      free_q [$];
   t_rob_id    open_q [$];
   ref_instr_t taken_q [$];
   row_t       stim [$];
   t_rob_id    m_head;
   t_rob_id    m_tail;
   int         m_count;
   int         pops_done;
   logic       saw_full;

   rename_alloc_top dut_i (.*);

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(string reason);
      $display("Error at time %0t: %s", $time, reason);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic report_mismatch(string msg);
      $display("Mismatch at time %0t: %s", $time, msg);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) report_mismatch($sformatf("%s got %0b expected %0b", name, got, exp));
   endtask

   task automatic check_preg(string name, t_preg got, t_preg exp);
      if (got !== exp) report_mismatch($sformatf("%s got p%0d expected p%0d", name, got, exp));
   endtask

   task automatic check_robid(string name, t_rob_id got, t_rob_id exp);
      if (got !== exp) report_mismatch($sformatf("%s got %0d expected %0d", name, got, exp));
   endtask

   task automatic check_disp(t_rob_id robid, t_preg pdst, logic has_dest, t_preg psrc1,
                             t_preg psrc2, logic use2, logic pdg1, logic pdg2,
                             t_rob_id srob1, t_rob_id srob2);
      check_robid("disp_robid", disp_robid, robid);
      if (has_dest) check_preg("disp_pdst", disp_pdst, pdst);
      check_preg("disp_psrc1", disp_psrc1, psrc1);
      check_bit("disp_pdg1", disp_pdg1, pdg1);
      if (pdg1) check_robid("disp_src_robid1", disp_src_robid1, srob1);
      if (use2) begin
         check_preg("disp_psrc2", disp_psrc2, psrc2);
         check_bit("disp_pdg2", disp_pdg2, pdg2);
         if (pdg2) check_robid("disp_src_robid2", disp_src_robid2, srob2);
      end
   endtask

   task automatic check_op(t_alu_op op, logic [31:0] imm, logic illegal, logic is_imm,
                           logic use2);
      check_bit("disp_illegal", disp_illegal, illegal);
      if (!illegal) begin
         if (disp_op !== op) begin
            report_mismatch($sformatf("disp_op got %s expected %s", disp_op.name(), op.name()));
         end
         check_bit("disp_use_rs2", disp_use_rs2, use2);
         if (is_imm && disp_imm !== imm) begin
            report_mismatch($sformatf("disp_imm got %h expected %h", disp_imm, imm));
         end
      end
   endtask

   task automatic check_retire(t_rob_id exp);
      check_robid("retire_robid", retire_robid, exp);
   endtask

   function automatic t_instr_word enc_r(logic [6:0] f7, t_areg rs2, t_areg rs1,
                                         logic [2:0] f3, t_areg rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic t_instr_word enc_i(logic [11:0] imm, t_areg rs1, logic [2:0] f3,
                                         t_areg rd);
      return {imm, rs1, f3, rd, OPC_OP_IMM};
   endfunction

   task automatic add_row(t_instr_word word, t_alu_op op, logic illegal, logic stall, int comp);
      row_t r;
      r.word    = word;
      r.op      = op;
      r.illegal = illegal;
      r.stall   = stall;
      r.comp    = comp;
      stim.push_back(r);
   endtask

   // Field positions of the R and I formats; illegal words carry nothing.
   function automatic ref_instr_t decode_ref(row_t r);
      ref_instr_t d;
      d = '{op: r.op, illegal: r.illegal, rd: '0, rs1: '0, rs2: '0,
            use2: 1'b0, is_imm: 1'b0, imm: '0};
      if (!r.illegal) begin
         d.rd  = r.word[11:7];
         d.rs1 = r.word[19:15];
         if (r.word[6:0] == OPC_OP) begin
            d.rs2  = r.word[24:20];
            d.use2 = 1'b1;
         end else begin
            d.is_imm = 1'b1;
            d.imm    = {{20{r.word[31]}}, r.word[31:20]};
         end
      end
      return d;
   endfunction

   function automatic row_t random_row();
      row_t        r;
      t_areg       rd;
      t_areg       rs1;
      t_areg       rs2;
      logic [11:0] imm;
      int          kind;
      kind      = $urandom_range(0, 7);
      rd        = t_areg'($urandom_range(0, 7));
      rs1       = t_areg'($urandom_range(0, 7));
      rs2       = t_areg'($urandom_range(0, 7));
      imm       = 12'($urandom);
      r.illegal = 1'b0;
      r.stall   = ($urandom_range(0, 3) == 0);
      r.comp    = ($urandom_range(0, 3) == 0) ? COMP_NONE : COMP_RANDOM;
      case (kind)
         0: begin r.word = enc_r(7'h00, rs2, rs1, 3'b000, rd); r.op = ALU_ADD; end
         1: begin r.word = enc_r(7'h20, rs2, rs1, 3'b000, rd); r.op = ALU_SUB; end
         2: begin r.word = enc_r(7'h00, rs2, rs1, 3'b111, rd); r.op = ALU_AND; end
         3: begin r.word = enc_r(7'h00, rs2, rs1, 3'b110, rd); r.op = ALU_OR; end
         4: begin r.word = enc_i(imm, rs1, 3'b000, rd); r.op = ALU_ADD; end
         5: begin r.word = enc_i(imm, rs1, 3'b100, rd); r.op = ALU_XOR; end
         6: begin r.word = enc_i(imm, rs1, 3'b010, rd); r.op = ALU_SLT; end
         default: begin r.word = enc_i({7'h00, imm[4:0]}, rs1, 3'b101, rd); r.op = ALU_SRL; end
      endcase
      return r;
   endfunction

   task automatic build_table();
      // Independent R and I forms right after reset.
      add_row(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1), ALU_ADD, 0, 0, COMP_NONE);
      add_row(enc_i(12'hffb, 5'd5, 3'b000, 5'd4), ALU_ADD, 0, 0, COMP_NONE);
      add_row(enc_r(7'h00, 5'd8, 5'd7, 3'b100, 5'd6), ALU_XOR, 0, 0, COMP_NONE);
      add_row(enc_i(12'h7ff, 5'd10, 3'b110, 5'd9), ALU_OR, 0, 0, COMP_NONE);
      add_row(enc_r(7'h20, 5'd13, 5'd12, 3'b000, 5'd11), ALU_SUB, 0, 0, COMP_NONE);
      add_row(enc_i(12'h800, 5'd15, 3'b010, 5'd14), ALU_SLT, 0, 0, COMP_NONE);
      // Readers of producers that have not completed yet.
      add_row(enc_r(7'h00, 5'd4, 5'd1, 3'b000, 5'd16), ALU_ADD, 0, 0, COMP_YOUNGEST);
      add_row(enc_r(7'h00, 5'd0, 5'd16, 3'b111, 5'd17), ALU_AND, 0, 0, COMP_YOUNGEST);
      add_row(enc_i(12'h003, 5'd16, 3'b001, 5'd18), ALU_SLL, 0, 0, COMP_OLDEST);
      add_row(enc_r(7'h00, 5'd18, 5'd17, 3'b101, 5'd19), ALU_SRL, 0, 0, COMP_YOUNGEST);
      add_row(enc_r(7'h00, 5'd6, 5'd16, 3'b010, 5'd23), ALU_SLT, 0, 0, COMP_OLDEST);
      // Writes to x0 and illegal encodings.
      add_row(32'h0000_0073, ALU_ADD, 1, 0, COMP_OLDEST);
      add_row(enc_i(12'h001, 5'd1, 3'b000, 5'd0), ALU_ADD, 0, 0, COMP_OLDEST);
      add_row(enc_r(7'h20, 5'd2, 5'd1, 3'b001, 5'd5), ALU_ADD, 1, 0, COMP_YOUNGEST);
      add_row(enc_r(7'h00, 5'd1, 5'd0, 3'b001, 5'd20), ALU_SLL, 0, 0, COMP_YOUNGEST);
      // Reservation station stall.
      add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd21), ALU_OR, 0, 1, COMP_OLDEST);
      add_row(enc_r(7'h00, 5'd3, 5'd21, 3'b111, 5'd22), ALU_AND, 0, 1, COMP_YOUNGEST);
      add_row(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd1), ALU_ADD, 0, 0, COMP_OLDEST);
      add_row(enc_r(7'h00, 5'd16, 5'd16, 3'b000, 5'd24), ALU_ADD, 0, 0, COMP_OLDEST);
      // No completions until the ROB is full.
      for (int i = 0; i < 18; i++) begin
         add_row(enc_i(12'(i + 1), t_areg'(i % 6 + 25), 3'b000, t_areg'(i % 6 + 25)),
                 ALU_ADD, 0, 0, COMP_NONE);
      end
      for (int i = 0; i < 4; i++) begin
         add_row(enc_r(7'h00, 5'd26, 5'd25, 3'b100, 5'd30), ALU_XOR, 0, 0, COMP_OLDEST);
      end
   endtask

   task automatic reset_model();
      for (int i = 0; i < `NUM_AREGS; i++) begin
         m_rat[i] = t_preg'(i);
         lw_v[i]  = 1'b0;
         lw_id[i] = '0;
      end
      for (int i = `NUM_AREGS; i < `NUM_PREGS; i++) free_q.push_back(t_preg'(i));
      for (int i = 0; i < `ROB_DEPTH; i++) m_done[i] = 1'b0;
      m_head    = '0;
      m_tail    = '0;
      m_count   = 0;
      pops_done = 0;
      saw_full  = 1'b0;
   endtask

   task automatic drive_completion(int sel);
      int idx;
      complete_valid = 1'b0;
      if (sel != COMP_NONE && open_q.size() != 0) begin
         case (sel)
            COMP_OLDEST:   idx = 0;
            COMP_YOUNGEST: idx = open_q.size() - 1;
            default:       idx = $urandom_range(0, open_q.size() - 1);
         endcase
         complete_valid = 1'b1;
         complete_robid = open_q[idx];
         open_q.delete(idx);
      end
   endtask

   // A held row gets the oldest entry completed once the ROB is full.
   task automatic apply_row(row_t r, logic first);
      instr_valid = 1'b1;
      instr_word  = r.word;
      rs_stall    = first ? r.stall : 1'b0;
      if (first) drive_completion(r.comp);
      else drive_completion((m_count == `ROB_DEPTH) ? COMP_OLDEST : COMP_NONE);
   endtask

   task automatic process_edge(logic stalled);
      ref_instr_t ins;
      logic       exp_retire;
      logic       has_dest;
      logic       pdg1;
      logic       pdg2;
      t_preg      pdst;
      exp_retire = (m_count > 0) && m_done[m_head];
      check_bit("retire_valid", retire_valid, exp_retire);
      if (exp_retire) check_retire(m_head);
      if (stalled) check_bit("disp_valid during stall", disp_valid, 1'b0);
      if (disp_valid) begin
         if (taken_q.size() == 0) abort_run("dispatch seen with no instruction in flight");
         ins      = taken_q.pop_front();
         has_dest = !ins.illegal && (ins.rd != '0);
         pdg1 = (ins.rs1 != '0) && lw_v[ins.rs1] && !m_done[lw_id[ins.rs1]];
         pdg2 = (ins.rs2 != '0) && lw_v[ins.rs2] && !m_done[lw_id[ins.rs2]];
         pdst = has_dest ? free_q[0] : '0;
         check_disp(m_tail, pdst, has_dest, m_rat[ins.rs1], m_rat[ins.rs2], ins.use2,
                    pdg1, pdg2, lw_id[ins.rs1], lw_id[ins.rs2]);
         check_op(ins.op, ins.imm, ins.illegal, ins.is_imm, ins.use2);
         if (has_dest) begin
            m_old[m_tail] = m_rat[ins.rd];
            m_rat[ins.rd] = free_q.pop_front();
            pops_done++;
         end
      end
      if (exp_retire) begin
         if (m_has_dest[m_head]) begin
            free_q.push_back(m_old[m_head]);
            if (lw_v[m_rd[m_head]] && lw_id[m_rd[m_head]] == m_head) lw_v[m_rd[m_head]] = 1'b0;
         end
         m_head = m_head + 1'b1;
         m_count--;
      end
      if (disp_valid) begin
         m_done[m_tail]     = 1'b0;
         m_has_dest[m_tail] = has_dest;
         m_rd[m_tail]       = ins.rd;
         if (has_dest) begin
            lw_v[ins.rd]  = 1'b1;
            lw_id[ins.rd] = m_tail;
         end
         open_q.push_back(m_tail);
         m_tail = m_tail + 1'b1;
         m_count++;
      end
      if (complete_valid) m_done[complete_robid] = 1'b1;
   endtask

   task automatic run_cycle(row_t r, output logic taken);
      logic stalled;
      @(negedge clk);
      stalled = !fe_ready;
      taken   = instr_valid && fe_ready;
      check_bit("fe_ready", fe_ready, !(rs_stall || m_count == `ROB_DEPTH));
      if (m_count == `ROB_DEPTH) saw_full = 1'b1;
      @(posedge clk);
      #10;
      process_edge(stalled);
      if (taken) taken_q.push_back(decode_ref(r));
   endtask

   initial begin
      int limit;
      #1;
      limit = 200 + 20 * stim.size();
      repeat (limit) @(posedge clk);
      abort_run($sformatf("run did not finish within %0d cycles, the DUT appears hung", limit));
   end

   initial begin
      row_t idle;
      logic taken;
      logic first;
      reset          = 1'b1;
      instr_valid    = 1'b0;
      instr_word     = '0;
      rs_stall       = 1'b0;
      complete_valid = 1'b0;
      complete_robid = '0;
      void'($urandom(32'ha210));
      build_table();
      for (int i = 0; i < NUM_RANDOM; i++) stim.push_back(random_row());
      reset_model();
      idle = '{word: '0, op: ALU_ADD, illegal: 1'b0, stall: 1'b0, comp: COMP_NONE};
      repeat (4) @(posedge clk);
      #10;
      reset = 1'b0;
      foreach (stim[i]) begin
         first = 1'b1;
         taken = 1'b0;
         while (!taken) begin
            apply_row(stim[i], first);
            first = 1'b0;
            run_cycle(stim[i], taken);
         end
      end
      // Drain the pipeline and retire everything left.
      instr_valid = 1'b0;
      rs_stall    = 1'b0;
      while (taken_q.size() != 0 || m_count != 0) begin
         drive_completion(COMP_OLDEST);
         run_cycle(idle, taken);
      end
      complete_valid = 1'b0;
      if (!saw_full || pops_done <= `NUM_PREGS - `NUM_AREGS) begin
         abort_run("the run never filled the ROB or never reused a freed register");
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule
